// ==== Makefile ====
TOP := tb_mem_resp_wh_tx

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the result"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== bench/mem_resp_wh_tx_assert.sv ====
/*
  protocol checks for the memory response transmit path
  bound into mem_resp_wh_tx
*/
`timescale 1ns/1ps

module mem_resp_wh_tx_assert (
  input logic              clk_i,
  input logic              rst_i,
  input logic              resp_v_i,
  input logic              busy_i,
  input wh_mem_pkg::flit_t flit_i,
  input logic              flit_v_i,
  input logic              flit_last_i
);

  import wh_mem_pkg::*;

  int      fail_count = 0;
  logic    in_pkt_r;
  wh_len_t len_r;
  wh_len_t idx_r;
  logic    first_flit;
  wh_len_t pkt_len;
  wh_len_t flit_idx;

  assign first_flit = flit_v_i & ~in_pkt_r;
  assign pkt_len    = first_flit ? flit_i[wh_len_offset_lp +: len_width_lp] : len_r;
  assign flit_idx   = first_flit ? '0 : idx_r; // position of the current flit

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_pkt_r <= 1'b0;
      len_r    <= '0;
      idx_r    <= '0;
    end else if (flit_v_i) begin
      in_pkt_r <= ~flit_last_i;
      len_r    <= pkt_len;
      idx_r    <= flit_idx + 1'b1;
    end
  end

  no_resp_while_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_v_i |-> !busy_i)
    else begin
      $error("resp_v_i raised while busy_o was high");
      fail_count++;
    end

  last_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    flit_last_i |-> flit_v_i)
    else begin
      $error("flit_last_o high without flit_v_o");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clk_i)
    rst_i |=> !busy_i && !flit_v_i && !flit_last_i)
    else begin
      $error("outputs not low in the cycle after reset");
      fail_count++;
    end

  valid_until_last: assert property (@(posedge clk_i) disable iff (rst_i)
    flit_v_i && !flit_last_i |=> flit_v_i)
    else begin
      $error("flit_v_o dropped before flit_last_o");
      fail_count++;
    end

  len_matches_count: assert property (@(posedge clk_i) disable iff (rst_i)
    flit_last_i |-> pkt_len == flit_idx)
    else begin
      $error("len field does not match the number of flits sent");
      fail_count++;
    end

endmodule

bind mem_resp_wh_tx mem_resp_wh_tx_assert protocol_chk (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .resp_v_i    (resp_v_i),
  .busy_i      (busy_o),
  .flit_i      (flit_o),
  .flit_v_i    (flit_v_o),
  .flit_last_i (flit_last_o)
);

// ==== bench/tb_mem_resp_wh_tx.sv ====
/*
  testbench for the memory response transmit path
  sends responses, reassembles the flits and compares them with expected packets
*/
`timescale 1ns/1ps

module tb_mem_resp_wh_tx;

  import wh_mem_pkg::*;

  logic       clk_i = 1'b0;
  logic       rst_i;
  logic       resp_v_i;
  mem_hdr_t   resp_hdr_i;
  mem_data_t  resp_data_i;
  cord_t      dst_cord_i;
  cid_t       dst_cid_i;
  cord_t      src_cord_i;
  cid_t       src_cid_i;
  logic       busy_o;
  flit_t      flit_o;
  logic       flit_v_o;
  logic       flit_last_o;

  logic [31:0] lcg_state = 32'h3500;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          bad_tests = 0;
  int          test_err_base;
  string       test_name;
  int          flit_idx = 0;
  int          cur_len = 0;
  wh_packet_t  cur_pkt;
  wh_packet_t  exp_pkts[$];
  int          exp_lens[$];

  mem_resp_wh_tx UUT (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // the len field is ceil((48 + 8*bytes) / 32) - 1 flits after the first
  function automatic int expected_len(input mem_hdr_t hdr);
    int bytes;
    bytes = 1 << hdr[5:3];
    case (hdr[2:0])
      3'd0, 3'd1:       return (48 + 8*bytes + 31) / 32 - 1;
      3'd2, 3'd3, 3'd4: return 1;
      default:          return 0;
    endcase
  endfunction

  function automatic wh_packet_t expected_packet(input mem_hdr_t hdr, input mem_data_t data,
                                                 input cord_t dcord, input cid_t dcid);
    wh_packet_t pkt;
    pkt = '0;
    if (hdr[2:0] <= 3'd4) begin // unknown types stay all zero
      pkt[3:0]    = dcord;
      pkt[7:4]    = 4'(expected_len(hdr));
      pkt[9:8]    = dcid;
      pkt[13:10]  = src_cord_i;
      pkt[15:14]  = src_cid_i;
      pkt[47:16]  = hdr;
      pkt[175:48] = data;
    end
    return pkt;
  endfunction

  function automatic int total_errors();
    return err_cnt + UUT.protocol_chk.fail_count;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, got);
    err_cnt++;
  endtask

  task automatic note_failure(input string why);
    $display("error at %0d ns: %s", $time, why);
    err_cnt++;
  endtask

  task automatic abort_run(input string why);
    $display("timeout at %0d ns: %s", $time, why);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = total_errors();
  endtask

  task automatic end_test();
    int errs;
    errs = total_errors() - test_err_base;
    test_cnt++;
    if (errs != 0) bad_tests++;
    $display("test %0d %s: %s (%0d errors)", test_cnt, test_name, errs == 0 ? "ok" : "bad", errs);
  endtask

  task automatic send_resp(input logic [2:0] msg, input logic [2:0] size);
    mem_hdr_t  hdr;
    mem_data_t data;
    logic [31:0] r;
    int waited;
    r    = lcg_next();
    hdr  = {r[25:0], size, msg};
    data = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
    r    = lcg_next(); // fresh destination for every response
    waited = 0;
    @(negedge clk_i);
    while (busy_o) begin
      waited++;
      if (waited > 50) abort_run("busy_o never dropped");
      @(negedge clk_i);
    end
    exp_pkts.push_back(expected_packet(hdr, data, r[3:0], r[5:4]));
    exp_lens.push_back(expected_len(hdr));
    @(posedge clk_i);
    resp_v_i    <= 1'b1;
    resp_hdr_i  <= hdr;
    resp_data_i <= data;
    dst_cord_i  <= r[3:0];
    dst_cid_i   <= r[5:4];
    @(posedge clk_i);
    resp_v_i    <= 1'b0;
    resp_hdr_i  <= ~hdr; // upstream moves on while the entry is held
    resp_data_i <= ~data;
    dst_cord_i  <= ~r[3:0];
    dst_cid_i   <= ~r[5:4];
  endtask

  task automatic wait_last();
    int waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > 50) abort_run("flit_last_o never came");
    end while (!flit_last_o);
  endtask

  // reassembly monitor checks one flit per negative edge
  always @(negedge clk_i) begin
    if (!rst_i && flit_v_o) begin
      if (flit_idx == 0) begin
        assert (exp_pkts.size() > 0) else note_failure("flit sent with no response outstanding");
        if (exp_pkts.size() > 0) begin
          cur_pkt = exp_pkts.pop_front();
          cur_len = exp_lens.pop_front();
        end
      end
      if (flit_idx <= cur_len) begin
        assert (flit_o == cur_pkt[flit_idx*32 +: 32])
          else report_mismatch("flit_o", cur_pkt[flit_idx*32 +: 32], flit_o);
      end
      assert (flit_last_o == (flit_idx == cur_len))
        else report_mismatch("flit_last_o", 32'(flit_idx == cur_len), 32'(flit_last_o));
      flit_idx = flit_last_o ? 0 : flit_idx + 1;
    end
  end

  initial begin
    rst_i       = 1'b1;
    resp_v_i    = 1'b0;
    resp_hdr_i  = '0;
    resp_data_i = '0;
    dst_cord_i  = '0;
    dst_cid_i   = '0;
    src_cord_i  = 4'h3;
    src_cid_i   = 2'd1;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    start_test("idle after reset");
    repeat (10) begin
      @(negedge clk_i);
      assert (!flit_v_o && !busy_o) else note_failure("output active with no response sent");
    end
    end_test();

    start_test("read lengths");
    for (int m = 0; m < 2; m++) begin
      for (int s = 0; s < 5; s++) begin
        send_resp(3'(m), 3'(s));
        wait_last();
      end
    end
    end_test();

    start_test("ack lengths");
    for (int m = 2; m < 5; m++) begin
      for (int s = 0; s < 5; s += 2) begin
        send_resp(3'(m), 3'(s));
        wait_last();
      end
    end
    end_test();

    start_test("unknown types");
    for (int m = 5; m < 8; m++) begin
      send_resp(3'(m), 3'd4);
      wait_last();
    end
    end_test();

    start_test("coordinates and ids");
    repeat (4) begin
      @(posedge clk_i);
      src_cord_i <= 4'(lcg_next());
      src_cid_i  <= 2'(lcg_next());
      send_resp(3'd0, 3'd1);
      wait_last();
    end
    end_test();

    start_test("back to back");
    send_resp(3'd0, 3'd4);
    send_resp(3'd1, 3'd3); // captured while the first is still in flight
    @(negedge clk_i);
    assert (busy_o && flit_v_o) else note_failure("second response not held during first packet");
    wait_last();
    @(negedge clk_i);
    assert (flit_v_o) else note_failure("idle cycle between back-to-back packets");
    wait_last();
    @(negedge clk_i);
    assert (exp_pkts.size() == 0) else note_failure("responses left without flits");
    end_test();

    $display("tests %0d, failing tests %0d, errors %0d", test_cnt, bad_tests, total_errors());
    if (bad_tests == 0 && total_errors() == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
source/wh_mem_pkg.sv
source/mem_resp_capture.sv
source/mem_resp_packet_encode.sv
source/wh_flit_serializer.sv
source/mem_resp_wh_tx.sv
bench/mem_resp_wh_tx_assert.sv
bench/tb_mem_resp_wh_tx.sv

// ==== source/mem_resp_capture.sv ====
/*
  memory response capture
  one-entry holding register for a response and its destination
*/
`timescale 1ns/1ps

module mem_resp_capture (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  resp_v_i,
  input  wh_mem_pkg::mem_hdr_t  resp_hdr_i,
  input  wh_mem_pkg::mem_data_t resp_data_i,
  input  wh_mem_pkg::cord_t     dst_cord_i,
  input  wh_mem_pkg::cid_t      dst_cid_i,
  input  logic                  load_i,
  output wh_mem_pkg::mem_hdr_t  hdr_o,
  output wh_mem_pkg::mem_data_t data_o,
  output wh_mem_pkg::cord_t     dst_cord_o,
  output wh_mem_pkg::cid_t      dst_cid_o,
  output logic                  full_o,
  output logic                  busy_o
);

  logic full_r;
  logic accept;

  assign accept = resp_v_i & ~full_r; // upstream keeps off while busy

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_r <= 1'b0;
    end else if (accept) begin
      full_r <= 1'b1;
    end else if (load_i) begin
      full_r <= 1'b0; // serializer took the entry
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      hdr_o      <= resp_hdr_i;
      data_o     <= resp_data_i;
      dst_cord_o <= dst_cord_i;
      dst_cid_o  <= dst_cid_i; // destination stays with its response
    end
  end

  assign full_o = full_r;
  assign busy_o = full_r;

endmodule

// ==== source/mem_resp_packet_encode.sv ====
/*
  memory response packet encoder
  packs a latched response into a wormhole packet and picks its length field
*/
`timescale 1ns/1ps

module mem_resp_packet_encode (
  input  wh_mem_pkg::mem_hdr_t   hdr_i,
  input  wh_mem_pkg::mem_data_t  data_i,
  input  wh_mem_pkg::cord_t      src_cord_i,
  input  wh_mem_pkg::cord_t      dst_cord_i,
  input  wh_mem_pkg::cid_t       src_cid_i,
  input  wh_mem_pkg::cid_t       dst_cid_i,
  output wh_mem_pkg::wh_packet_t packet_o,
  output wh_mem_pkg::wh_len_t    len_o
);

  import wh_mem_pkg::*;

  mem_msg_type_e msg_type;
  mem_msg_size_e msg_size;
  wh_len_t       data_len;
  logic          msg_known;

  assign msg_type = mem_msg_type_e'(hdr_i[mem_hdr_type_offset_lp +: mem_msg_type_width_lp]);
  assign msg_size = mem_msg_size_e'(hdr_i[mem_hdr_size_offset_lp +: mem_msg_size_width_lp]);

  always_comb begin
    case (msg_size)
      e_mem_msg_size_1:  data_len = wh_data_len_1_lp;
      e_mem_msg_size_2:  data_len = wh_data_len_2_lp;
      e_mem_msg_size_4:  data_len = wh_data_len_4_lp;
      e_mem_msg_size_8:  data_len = wh_data_len_8_lp;
      e_mem_msg_size_16: data_len = wh_data_len_16_lp;
      default:           data_len = '0; // illegal size
    endcase
  end

  always_comb begin
    len_o     = '0;
    msg_known = 1'b1;
    case (msg_type)
      e_mem_msg_rd,
      e_mem_msg_uc_rd: len_o = data_len;
      e_mem_msg_wr,
      e_mem_msg_uc_wr,
      e_mem_msg_pre:   len_o = wh_ack_len_lp; // acks carry no data flits
      default:         msg_known = 1'b0;
    endcase
  end

  always_comb begin
    packet_o = '0;
    // an unknown message leaves the whole packet zero
    if (msg_known) begin
      packet_o[wh_cord_offset_lp     +: cord_width_lp]     = dst_cord_i;
      packet_o[wh_len_offset_lp      +: len_width_lp]      = len_o;
      packet_o[wh_cid_offset_lp      +: cid_width_lp]      = dst_cid_i;
      packet_o[wh_src_cord_offset_lp +: cord_width_lp]     = src_cord_i;
      packet_o[wh_src_cid_offset_lp  +: cid_width_lp]      = src_cid_i;
      packet_o[wh_msg_offset_lp      +: mem_hdr_width_lp]  = hdr_i;
      packet_o[wh_data_offset_lp     +: mem_data_width_lp] = data_i;
    end
  end

endmodule

// ==== source/mem_resp_wh_tx.sv ====
/*
  memory response wormhole transmit path
  capture, encode and serialize memory responses into flits
*/
`timescale 1ns/1ps

module mem_resp_wh_tx (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  resp_v_i,
  input  wh_mem_pkg::mem_hdr_t  resp_hdr_i,
  input  wh_mem_pkg::mem_data_t resp_data_i,
  input  wh_mem_pkg::cord_t     dst_cord_i,
  input  wh_mem_pkg::cid_t      dst_cid_i,
  input  wh_mem_pkg::cord_t     src_cord_i,
  input  wh_mem_pkg::cid_t      src_cid_i,
  output logic                  busy_o,
  output wh_mem_pkg::flit_t     flit_o,
  output logic                  flit_v_o,
  output logic                  flit_last_o
);

  import wh_mem_pkg::*;

  mem_hdr_t   hdr_lo;
  mem_data_t  data_lo;
  cord_t      dst_cord_lo;
  cid_t       dst_cid_lo;
  logic       full_lo;
  logic       load_lo;
  wh_packet_t packet_lo;
  wh_len_t    len_lo;

  mem_resp_capture capture (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .resp_v_i    (resp_v_i),
    .resp_hdr_i  (resp_hdr_i),
    .resp_data_i (resp_data_i),
    .dst_cord_i  (dst_cord_i),
    .dst_cid_i   (dst_cid_i),
    .load_i      (load_lo),
    .hdr_o       (hdr_lo),
    .data_o      (data_lo),
    .dst_cord_o  (dst_cord_lo),
    .dst_cid_o   (dst_cid_lo),
    .full_o      (full_lo),
    .busy_o      (busy_o)
  );

  mem_resp_packet_encode encode (
    .hdr_i      (hdr_lo),
    .data_i     (data_lo),
    .src_cord_i (src_cord_i),
    .dst_cord_i (dst_cord_lo),
    .src_cid_i  (src_cid_i),
    .dst_cid_i  (dst_cid_lo),
    .packet_o   (packet_lo),
    .len_o      (len_lo)
  );

  wh_flit_serializer serializer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .full_i      (full_lo),
    .packet_i    (packet_lo),
    .len_i       (len_lo),
    .load_o      (load_lo),
    .flit_o      (flit_o),
    .flit_v_o    (flit_v_o),
    .flit_last_o (flit_last_o)
  );

endmodule

// ==== source/wh_flit_serializer.sv ====
/*
  wormhole flit serializer
  loads an encoded packet and sends it as 32-bit flits, one per cycle
*/
`timescale 1ns/1ps

module wh_flit_serializer (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   full_i,
  input  wh_mem_pkg::wh_packet_t packet_i,
  input  wh_mem_pkg::wh_len_t    len_i,
  output logic                   load_o,
  output wh_mem_pkg::flit_t      flit_o,
  output logic                   flit_v_o,
  output logic                   flit_last_o
);

  import wh_mem_pkg::*;

  typedef enum logic {
    e_idle,
    e_send
  } ser_state_e;

  ser_state_e state_r;
  wh_packet_t shift_r;
  wh_len_t    cnt_r;

  assign flit_v_o    = (state_r == e_send);
  assign flit_last_o = flit_v_o & (cnt_r == '0);

  // loading on the last flit keeps back-to-back packets gapless
  assign load_o = full_i & ((state_r == e_idle) | flit_last_o);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= e_idle;
      cnt_r   <= '0;
    end else if (load_o) begin
      state_r <= e_send;
      cnt_r   <= len_i; // flits left after the first one
    end else if (flit_last_o) begin
      state_r <= e_idle;
    end else if (flit_v_o) begin
      cnt_r <= cnt_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_o) begin
      shift_r <= packet_i;
    end else if (flit_v_o) begin
      shift_r <= shift_r >> flit_width_lp; // next flit moves to the bottom
    end
  end

  assign flit_o = shift_r[flit_width_lp-1:0];

endmodule

// ==== source/wh_mem_pkg.sv ====
/*
  wormhole memory response package
  message enums, field widths, packet offsets and flit length constants
*/
package wh_mem_pkg;

  localparam int mem_msg_type_width_lp = 3;
  localparam int mem_msg_size_width_lp = 3;
  localparam int mem_addr_width_lp     = 26;
  localparam int mem_data_width_lp     = 128;
  localparam int mem_hdr_width_lp      = mem_msg_type_width_lp + mem_msg_size_width_lp
                                         + mem_addr_width_lp;

  localparam int cord_width_lp  = 4;
  localparam int cid_width_lp   = 2;
  localparam int len_width_lp   = 4;
  localparam int flit_width_lp  = 32;

  localparam int wh_max_flits_lp    = 6;
  localparam int wh_packet_width_lp = wh_max_flits_lp * flit_width_lp;
  localparam int wh_hdr_width_lp    = 48; // everything below the data field

  // header field positions
  localparam int mem_hdr_type_offset_lp = 0;
  localparam int mem_hdr_size_offset_lp = mem_msg_type_width_lp;

  // packet field positions from the low field up
  localparam int wh_cord_offset_lp     = 0;
  localparam int wh_len_offset_lp      = 4;
  localparam int wh_cid_offset_lp      = 8;
  localparam int wh_src_cord_offset_lp = 10;
  localparam int wh_src_cid_offset_lp  = 14;
  localparam int wh_msg_offset_lp      = 16;
  localparam int wh_data_offset_lp     = wh_hdr_width_lp;

  typedef enum logic [mem_msg_type_width_lp-1:0] {
    e_mem_msg_rd    = 3'd0,
    e_mem_msg_uc_rd = 3'd1,
    e_mem_msg_wr    = 3'd2,
    e_mem_msg_uc_wr = 3'd3,
    e_mem_msg_pre   = 3'd4
  } mem_msg_type_e;

  typedef enum logic [mem_msg_size_width_lp-1:0] {
    e_mem_msg_size_1  = 3'd0,
    e_mem_msg_size_2  = 3'd1,
    e_mem_msg_size_4  = 3'd2,
    e_mem_msg_size_8  = 3'd3,
    e_mem_msg_size_16 = 3'd4
  } mem_msg_size_e;

  typedef logic [mem_addr_width_lp-1:0]  mem_addr_t;
  typedef logic [mem_hdr_width_lp-1:0]   mem_hdr_t;
  typedef logic [mem_data_width_lp-1:0]  mem_data_t;
  typedef logic [cord_width_lp-1:0]      cord_t;
  typedef logic [cid_width_lp-1:0]       cid_t;
  typedef logic [len_width_lp-1:0]       wh_len_t;
  typedef logic [flit_width_lp-1:0]      flit_t;
  typedef logic [wh_packet_width_lp-1:0] wh_packet_t;

  // the len field counts flits after the first as ceil((hdr + 8*bytes) / flit) - 1
  localparam wh_len_t wh_ack_len_lp =
    wh_len_t'((wh_hdr_width_lp + flit_width_lp - 1) / flit_width_lp - 1);
  localparam wh_len_t wh_data_len_1_lp =
    wh_len_t'((wh_hdr_width_lp + 8*1 + flit_width_lp - 1) / flit_width_lp - 1);
  localparam wh_len_t wh_data_len_2_lp =
    wh_len_t'((wh_hdr_width_lp + 8*2 + flit_width_lp - 1) / flit_width_lp - 1);
  localparam wh_len_t wh_data_len_4_lp =
    wh_len_t'((wh_hdr_width_lp + 8*4 + flit_width_lp - 1) / flit_width_lp - 1);
  localparam wh_len_t wh_data_len_8_lp =
    wh_len_t'((wh_hdr_width_lp + 8*8 + flit_width_lp - 1) / flit_width_lp - 1);
  localparam wh_len_t wh_data_len_16_lp =
    wh_len_t'((wh_hdr_width_lp + 8*16 + flit_width_lp - 1) / flit_width_lp - 1);

endpackage
